// File: Makefile
# Verilator build and run of the fetch front-end testbench

sim:
	verilator --binary --timing -f flist.f --top-module fe_tb --Mdir obj_dir -o fe_sim
	./obj_dir/fe_sim | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: flist.f
logic/fe_pkg.sv
logic/fe_upd_if.sv
logic/fe_btb.sv
logic/fe_bht.sv
logic/fe_instr_scan.sv
logic/fe_pc_gen.sv
logic/fe_top.sv
tb/fe_tb.sv

// File: logic/fe_bht.sv
// Gshare branch history table of 2-bit counters, indexed by PC bits folded with global history

module fe_bht import fe_pkg::*;
#(
  parameter int unsigned bht_idx_width_p = 6
)
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic [vaddr_width-1:0] r_pc_i,
  input  logic [ghist_width-1:0] r_ghist_i,
  fe_bht_upd_if.dst              upd,
  output logic                   init_done_o,
  output fe_ctr_e                ctr_o,
  output logic                   pred_o
);

  localparam int unsigned entries_lp = 1 << bht_idx_width_p;

  fe_ctr_e ctr_mem [entries_lp];

  logic [bht_idx_width_p-1:0] init_cnt_r;
  logic                       init_done_r;
  logic [bht_idx_width_p-1:0] r_idx;
  logic [bht_idx_width_p-1:0] w_idx;

  // History longer than the index wraps around and is XORed in again
  function automatic logic [bht_idx_width_p-1:0] fold_hist(logic [ghist_width-1:0] h);
    logic [bht_idx_width_p-1:0] f;
    f = '0;
    for (int i = 0; i < ghist_width; i++)
      f[i % bht_idx_width_p] = f[i % bht_idx_width_p] ^ h[i];
    return f;
  endfunction

  function automatic fe_ctr_e ctr_step(fe_ctr_e c, logic taken);
    fe_ctr_e n;
    n = c;
    if (taken && (c != ctr_st))
      n = fe_ctr_e'(c + 2'd1);
    else if (!taken && (c != ctr_snt))
      n = fe_ctr_e'(c - 2'd1);
    return n;
  endfunction

  assign r_idx = r_pc_i[2 +: bht_idx_width_p] ^ fold_hist(r_ghist_i);
  assign w_idx = upd.pc[2 +: bht_idx_width_p] ^ fold_hist(upd.ghist);

  ////////////////////
  // Clear sweep
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      init_cnt_r  <= '0;
      init_done_r <= 1'b0;
    end
    else if (!init_done_r)
    begin
      init_cnt_r  <= init_cnt_r + bht_idx_width_p'(1);
      init_done_r <= (init_cnt_r == '1);
    end
  end

  assign init_done_o = init_done_r;

  // Counter comes from the metadata, no second read needed
  always_ff @(posedge clk_i)
  begin
    if (!init_done_r)
      ctr_mem[init_cnt_r] <= ctr_wnt;
    else if (upd.v)
      ctr_mem[w_idx] <= ctr_step(upd.ctr, upd.taken);
  end

  assign ctr_o  = ctr_mem[r_idx];
  assign pred_o = ctr_o[1];

  bht_no_write_in_init_a: assert property (@(posedge clk_i) disable iff (rst_i)
    upd.v |-> init_done_o);

endmodule

// File: logic/fe_btb.sv
// Direct-mapped branch target buffer, read combinationally for the IF1 next-PC choice

module fe_btb import fe_pkg::*;
#(
  parameter int unsigned btb_idx_width_p = 6
)
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic [vaddr_width-1:0] r_pc_i,
  fe_btb_upd_if.dst              upd,
  output logic                   init_done_o,
  output logic [vaddr_width-1:0] tgt_o,
  output logic                   tgt_v_o,
  output logic                   tgt_jmp_o
);

  localparam int unsigned entries_lp   = 1 << btb_idx_width_p;
  localparam int unsigned tag_width_lp = vaddr_width - 2 - btb_idx_width_p;

  logic                    valid_r [entries_lp];
  logic [tag_width_lp-1:0] tag_mem [entries_lp];
  logic                    jmp_mem [entries_lp];
  logic [vaddr_width-1:0]  tgt_mem [entries_lp];

  logic [btb_idx_width_p-1:0] init_cnt_r;
  logic                       init_done_r;

  logic [btb_idx_width_p-1:0] r_idx;
  logic [tag_width_lp-1:0]    r_tag;
  logic [btb_idx_width_p-1:0] w_idx;
  logic [tag_width_lp-1:0]    w_tag;

  assign r_idx = r_pc_i[2 +: btb_idx_width_p];
  assign r_tag = r_pc_i[vaddr_width-1 -: tag_width_lp];
  assign w_idx = upd.pc[2 +: btb_idx_width_p];
  assign w_tag = upd.pc[vaddr_width-1 -: tag_width_lp];

  ////////////////////
  // Clear sweep
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      init_cnt_r  <= '0;
      init_done_r <= 1'b0;
    end
    else if (!init_done_r)
    begin
      init_cnt_r  <= init_cnt_r + btb_idx_width_p'(1);
      init_done_r <= (init_cnt_r == '1);
    end
  end

  assign init_done_o = init_done_r;

  always_ff @(posedge clk_i)
  begin
    if (!init_done_r)
      valid_r[init_cnt_r] <= 1'b0;
    else if (upd.v)
      valid_r[w_idx] <= ~upd.clr;
  end

  always_ff @(posedge clk_i)
  begin
    if (init_done_r && upd.v)
    begin
      tag_mem[w_idx] <= w_tag;
      jmp_mem[w_idx] <= upd.jmp;
      tgt_mem[w_idx] <= upd.tgt;
    end
  end

  ////////////////////
  // Lookup
  assign tgt_v_o   = valid_r[r_idx] && (tag_mem[r_idx] == r_tag);
  assign tgt_jmp_o = jmp_mem[r_idx];
  assign tgt_o     = tgt_mem[r_idx];

  // Training only starts once the sweep is over
  btb_no_write_in_init_a: assert property (@(posedge clk_i) disable iff (rst_i)
    upd.v |-> init_done_o);

endmodule

// File: logic/fe_instr_scan.sv
// Combinational RV32 control-flow decode of the instruction in IF2, used for overrides

module fe_instr_scan import fe_pkg::*;
(
  input  logic [instr_width-1:0] instr_i,
  output fe_scan_s               scan_o
);

  localparam logic [6:0] op_branch_lp = 7'b1100011;
  localparam logic [6:0] op_jal_lp    = 7'b1101111;
  localparam logic [6:0] op_jalr_lp   = 7'b1100111;

  logic [6:0] opcode;
  logic [4:0] rd;
  logic [4:0] rs1;
  logic [2:0] funct3;
  logic       br;
  logic       jal;
  logic       jalr;

  logic [vaddr_width-1:0] imm_b;
  logic [vaddr_width-1:0] imm_j;
  logic [vaddr_width-1:0] imm_i;

  assign opcode = instr_i[6:0];
  assign rd     = instr_i[11:7];
  assign funct3 = instr_i[14:12];
  assign rs1    = instr_i[19:15];

  assign br   = (opcode == op_branch_lp);
  assign jal  = (opcode == op_jal_lp);
  assign jalr = (opcode == op_jalr_lp) && (funct3 == 3'b000);

  // B, J and I immediate formats
  assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
  assign imm_i = {{21{instr_i[31]}}, instr_i[30:20]};

  assign scan_o.is_br   = br;
  assign scan_o.is_jal  = jal;
  assign scan_o.is_jalr = jalr;
  // Link register x1 marks calls and returns
  assign scan_o.is_call = (jal || jalr) && (rd == 5'd1);
  assign scan_o.is_ret  = jalr && (rs1 == 5'd1) && (rd == 5'd0) && (imm_i == '0);
  assign scan_o.imm     = br ? imm_b : (jal ? imm_j : imm_i);

endmodule

// File: logic/fe_pc_gen.sv
// Next fetch PC selection over IF1/IF2 with BTB, BHT, return register and branch metadata

module fe_pc_gen import fe_pkg::*;
#(
  parameter int unsigned btb_idx_width_p = 6,
  parameter int unsigned bht_idx_width_p = 6
)
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   redirect_v_i,
  input  logic [vaddr_width-1:0] redirect_pc_i,
  input  logic                   redirect_br_v_i,
  input  logic                   redirect_br_taken_i,
  input  logic                   redirect_br_nonbr_i,
  input  logic [vaddr_width-1:0] redirect_br_pc_i,
  input  fe_br_meta_s            redirect_meta_i,
  input  logic                   attaboy_v_i,
  input  logic                   attaboy_taken_i,
  input  logic [vaddr_width-1:0] attaboy_pc_i,
  input  logic [vaddr_width-1:0] attaboy_tgt_i,
  input  fe_br_meta_s            attaboy_meta_i,
  input  logic [instr_width-1:0] fetch_i,
  input  logic                   fetch_v_i,
  output logic                   init_done_o,
  output logic [vaddr_width-1:0] next_fetch_o,
  output logic                   ovr_o,
  output logic                   fetch_instr_v_o,
  output logic [instr_width-1:0] fetch_instr_o,
  output logic [vaddr_width-1:0] fetch_pc_o,
  output fe_br_meta_s            fetch_meta_o
);

  fe_btb_upd_if btb_upd ();
  fe_bht_upd_if bht_upd ();

  logic [vaddr_width-1:0] next_pc;
  logic [vaddr_width-1:0] pc_if1_r;
  logic                   v_if1_r;
  logic [vaddr_width-1:0] pc_if2_r;
  logic [ghist_width-1:0] ghist_if2_r;
  fe_ctr_e                ctr_if2_r;
  logic                   src_btb_if2_r;
  logic [ghist_width-1:0] ghist_r;
  logic [vaddr_width-1:0] ret_addr_r;
  fe_br_meta_s            meta_n;
  fe_br_meta_s            meta_r;

  logic                   btb_init_done;
  logic [vaddr_width-1:0] btb_tgt;
  logic                   btb_tgt_v;
  logic                   btb_tgt_jmp;
  logic                   bht_init_done;
  fe_ctr_e                bht_ctr;
  logic                   bht_pred;
  logic                   btb_taken;

  fe_scan_s               scan;
  logic                   is_br;
  logic                   is_jal;
  logic                   is_call;
  logic                   is_ret;
  logic [vaddr_width-1:0] br_tgt;
  logic [vaddr_width-1:0] seq_pc;
  logic                   ovr_ret;
  logic                   ovr_taken;

  logic redir_btb_w;
  logic atta_btb_w;
  logic redir_bht_w;
  logic atta_bht_w;

  ////////////////////
  // IF1
  assign init_done_o = btb_init_done & bht_init_done;

  // Hold at reset_pc until the first fetch leaves IF1
  assign seq_pc    = v_if1_r ? pc_if1_r + vaddr_width'(4) : pc_if1_r;
  assign btb_taken = v_if1_r & btb_tgt_v & (btb_tgt_jmp | bht_pred);

  always_comb
  begin
    if (redirect_v_i)
      next_pc = redirect_pc_i;
    else if (ovr_ret)
      next_pc = ret_addr_r;
    else if (ovr_taken)
      next_pc = br_tgt;
    else if (btb_taken)
      next_pc = btb_tgt;
    else
      next_pc = seq_pc;
  end

  assign next_fetch_o = next_pc;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      pc_if1_r <= reset_pc;
      v_if1_r  <= 1'b0;
    end
    else
    begin
      pc_if1_r <= next_pc;
      v_if1_r  <= init_done_o;
    end
  end

  fe_btb #(
    .btb_idx_width_p(btb_idx_width_p)
  ) btb0 (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .r_pc_i     (pc_if1_r),
    .upd        (btb_upd),
    .init_done_o(btb_init_done),
    .tgt_o      (btb_tgt),
    .tgt_v_o    (btb_tgt_v),
    .tgt_jmp_o  (btb_tgt_jmp)
  );

  fe_bht #(
    .bht_idx_width_p(bht_idx_width_p)
  ) bht0 (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .r_pc_i     (pc_if1_r),
    .r_ghist_i  (ghist_r),
    .upd        (bht_upd),
    .init_done_o(bht_init_done),
    .ctr_o      (bht_ctr),
    .pred_o     (bht_pred)
  );

  ////////////////////
  // IF2
  always_ff @(posedge clk_i)
  begin
    pc_if2_r      <= pc_if1_r;
    ghist_if2_r   <= ghist_r;
    ctr_if2_r     <= bht_ctr;
    src_btb_if2_r <= btb_taken;
  end

  assign fetch_instr_v_o = fetch_v_i & ~redirect_v_i;
  assign fetch_instr_o   = fetch_i;
  assign fetch_pc_o      = pc_if2_r;

  fe_instr_scan scan0 (
    .instr_i(fetch_i),
    .scan_o (scan)
  );

  assign is_br   = fetch_instr_v_o & scan.is_br;
  assign is_jal  = fetch_instr_v_o & scan.is_jal;
  assign is_call = fetch_instr_v_o & scan.is_call;
  assign is_ret  = fetch_instr_v_o & scan.is_ret;
  assign br_tgt  = fetch_pc_o + scan.imm;

  // No override when IF1 already follows the right path
  assign ovr_ret   = is_ret & (pc_if1_r != ret_addr_r);
  assign ovr_taken = (is_jal | (is_br & ctr_if2_r[1])) & (pc_if1_r != br_tgt);
  assign ovr_o     = ovr_ret | ovr_taken;

  always_ff @(posedge clk_i)
  begin
    if (is_call)
      ret_addr_r <= fetch_pc_o + vaddr_width'(4);
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      ghist_r <= '0;
    else if (redirect_br_v_i)
      ghist_r <= redirect_meta_i.ghist;
    else if (is_br)
      ghist_r <= {ghist_r[ghist_width-2:0], ctr_if2_r[1]};
  end

  always_comb
  begin
    meta_n         = '0;
    meta_n.is_br   = scan.is_br;
    meta_n.is_jal  = scan.is_jal;
    meta_n.is_jalr = scan.is_jalr;
    meta_n.is_call = scan.is_call;
    meta_n.is_ret  = scan.is_ret;
    meta_n.src_btb = src_btb_if2_r;
    meta_n.src_ret = scan.is_ret & ~src_btb_if2_r;
    meta_n.ghist   = ghist_if2_r;
    meta_n.ctr     = ctr_if2_r;
  end

  always_ff @(posedge clk_i)
  begin
    if (fetch_instr_v_o)
      meta_r <= meta_n;
  end

  assign fetch_meta_o = meta_r;

  ////////////////////
  // Table training, redirect has the port
  assign redir_btb_w = redirect_br_v_i
    & (redirect_br_taken_i | (redirect_br_nonbr_i & redirect_meta_i.src_btb));
  assign atta_btb_w  = attaboy_v_i & attaboy_taken_i & ~attaboy_meta_i.src_btb & ~redir_btb_w;

  assign btb_upd.v   = redir_btb_w | atta_btb_w;
  assign btb_upd.clr = redir_btb_w & redirect_br_nonbr_i & redirect_meta_i.src_btb;
  assign btb_upd.jmp = redir_btb_w ? (redirect_meta_i.is_jal | redirect_meta_i.is_jalr)
                                   : (attaboy_meta_i.is_jal | attaboy_meta_i.is_jalr);
  assign btb_upd.pc  = redir_btb_w ? redirect_br_pc_i : attaboy_pc_i;
  assign btb_upd.tgt = redir_btb_w ? redirect_pc_i : attaboy_tgt_i;

  assign redir_bht_w = redirect_br_v_i & redirect_meta_i.is_br;
  assign atta_bht_w  = attaboy_v_i & attaboy_meta_i.is_br & ~redir_bht_w;

  assign bht_upd.v     = redir_bht_w | atta_bht_w;
  assign bht_upd.pc    = redir_bht_w ? redirect_br_pc_i : attaboy_pc_i;
  assign bht_upd.ghist = redir_bht_w ? redirect_meta_i.ghist : attaboy_meta_i.ghist;
  assign bht_upd.ctr   = redir_bht_w ? redirect_meta_i.ctr : attaboy_meta_i.ctr;
  assign bht_upd.taken = redir_bht_w ? redirect_br_taken_i : attaboy_taken_i;

  redir_br_has_redir_a: assert property (@(posedge clk_i) disable iff (rst_i)
    redirect_br_v_i |-> redirect_v_i);

endmodule

// File: logic/fe_pkg.sv
// Shared widths, reset address and branch-prediction types; imported by every front-end module
package fe_pkg;

  localparam int unsigned vaddr_width = 32;
  localparam int unsigned instr_width = 32;
  localparam int unsigned ghist_width = 8;

  // First fetch address after the tables have been cleared
  localparam logic [vaddr_width-1:0] reset_pc = 32'h0000_0100;

  // Saturating 2-bit counter, upper bit is the prediction
  typedef enum logic [1:0] {
    ctr_snt = 2'b00,
    ctr_wnt = 2'b01,
    ctr_wt  = 2'b10,
    ctr_st  = 2'b11
  } fe_ctr_e;

  // Control-flow class of one instruction plus its offset
  typedef struct packed {
    logic                   is_br;
    logic                   is_jal;
    logic                   is_jalr;
    logic                   is_call;
    logic                   is_ret;
    logic [vaddr_width-1:0] imm;
  } fe_scan_s;

  // Travels with each fetched instruction to the backend and back
  typedef struct packed {
    logic                   is_br;
    logic                   is_jal;
    logic                   is_jalr;
    logic                   is_call;
    logic                   is_ret;
    logic                   src_btb;
    logic                   src_ret;
    logic [ghist_width-1:0] ghist;
    fe_ctr_e                ctr;
  } fe_br_meta_s;

endpackage

// File: logic/fe_top.sv
// Front-end top level with plain ports; sets the BTB and BHT sizes for the PC generator

module fe_top import fe_pkg::*;
#(
  parameter int unsigned btb_idx_width_p = 6,
  parameter int unsigned bht_idx_width_p = 6
)
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   redirect_v_i,
  input  logic [vaddr_width-1:0] redirect_pc_i,
  input  logic                   redirect_br_v_i,
  input  logic                   redirect_br_taken_i,
  input  logic                   redirect_br_nonbr_i,
  input  logic [vaddr_width-1:0] redirect_br_pc_i,
  input  fe_br_meta_s            redirect_meta_i,
  input  logic                   attaboy_v_i,
  input  logic                   attaboy_taken_i,
  input  logic [vaddr_width-1:0] attaboy_pc_i,
  input  logic [vaddr_width-1:0] attaboy_tgt_i,
  input  fe_br_meta_s            attaboy_meta_i,
  input  logic [instr_width-1:0] fetch_i,
  input  logic                   fetch_v_i,
  output logic                   init_done_o,
  output logic [vaddr_width-1:0] next_fetch_o,
  output logic                   ovr_o,
  output logic                   fetch_instr_v_o,
  output logic [instr_width-1:0] fetch_instr_o,
  output logic [vaddr_width-1:0] fetch_pc_o,
  output fe_br_meta_s            fetch_meta_o
);

  fe_pc_gen #(
    .btb_idx_width_p(btb_idx_width_p),
    .bht_idx_width_p(bht_idx_width_p)
  ) pc_gen0 (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .redirect_v_i       (redirect_v_i),
    .redirect_pc_i      (redirect_pc_i),
    .redirect_br_v_i    (redirect_br_v_i),
    .redirect_br_taken_i(redirect_br_taken_i),
    .redirect_br_nonbr_i(redirect_br_nonbr_i),
    .redirect_br_pc_i   (redirect_br_pc_i),
    .redirect_meta_i    (redirect_meta_i),
    .attaboy_v_i        (attaboy_v_i),
    .attaboy_taken_i    (attaboy_taken_i),
    .attaboy_pc_i       (attaboy_pc_i),
    .attaboy_tgt_i      (attaboy_tgt_i),
    .attaboy_meta_i     (attaboy_meta_i),
    .fetch_i            (fetch_i),
    .fetch_v_i          (fetch_v_i),
    .init_done_o        (init_done_o),
    .next_fetch_o       (next_fetch_o),
    .ovr_o              (ovr_o),
    .fetch_instr_v_o    (fetch_instr_v_o),
    .fetch_instr_o      (fetch_instr_o),
    .fetch_pc_o         (fetch_pc_o),
    .fetch_meta_o       (fetch_meta_o)
  );

endmodule

// File: logic/fe_upd_if.sv
// Write ports of the BTB and BHT, driven by the PC generator from redirects and attaboys

interface fe_btb_upd_if import fe_pkg::*; ();

  logic                   v;
  logic                   clr;
  logic                   jmp;
  logic [vaddr_width-1:0] pc;
  logic [vaddr_width-1:0] tgt;

  modport src (
    output v, clr, jmp, pc, tgt
  );

  modport dst (
    input v, clr, jmp, pc, tgt
  );

endinterface

interface fe_bht_upd_if import fe_pkg::*; ();

  logic                   v;
  logic [vaddr_width-1:0] pc;
  logic [ghist_width-1:0] ghist;
  fe_ctr_e                ctr;
  // Resolved outcome of the branch
  logic                   taken;

  modport src (
    output v, pc, ghist, ctr, taken
  );

  modport dst (
    input v, pc, ghist, ctr, taken
  );

endinterface

// File: tb/fe_tb.sv
// Testbench for fe_top; replays tb/fe_trace.txt and checks the fetch stream, run with flist.f
module fe_tb import fe_pkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned idx_width = 6;
  localparam int unsigned rst_cycles = 5;

  logic clk_i, rst_i;
  logic redirect_v_i, redirect_br_v_i, redirect_br_taken_i, redirect_br_nonbr_i;
  logic [31:0] redirect_pc_i, redirect_br_pc_i;
  fe_br_meta_s redirect_meta_i;
  logic attaboy_v_i, attaboy_taken_i;
  logic [31:0] attaboy_pc_i, attaboy_tgt_i;
  fe_br_meta_s attaboy_meta_i;
  logic [31:0] fetch_i;
  logic fetch_v_i;
  logic init_done_o, ovr_o, fetch_instr_v_o;
  logic [31:0] next_fetch_o, fetch_instr_o, fetch_pc_o;
  fe_br_meta_s fetch_meta_o;

  logic [31:0] mem [logic [31:0]];
  int r_cyc[$], a_cyc[$];
  logic [31:0] r_pc[$], r_br_pc[$];
  logic [2:0] r_bits[$];
  fe_br_meta_s r_meta[$];
  logic a_taken[$];
  logic [31:0] a_pc[$], a_tgt[$];
  fe_br_meta_s a_meta[$];
  logic [31:0] e_pc[$], e_ovr[$], e_chk[$];
  int cycles, limit;

  fe_top #(
    .btb_idx_width_p(idx_width),
    .bht_idx_width_p(idx_width)
  ) dut0 (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic stop_on_error(string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
      stop_on_error("mismatch on the DUT outputs");
    end
  endtask

  // Unlisted words are ADDI x0 with an immediate folded from the address
  function automatic logic [31:0] mem_word(logic [31:0] a);
    if (mem.exists(a))
      return mem[a];
    return {a[11:0] ^ a[23:12] ^ {4'h0, a[31:24]}, 20'h00013};
  endfunction

  task automatic load_trace();
    int fd;
    int cyc;
    string line;
    byte kind;
    logic [31:0] v0, v1, v2, v3, v4, v5;
    fd = $fopen("tb/fe_trace.txt", "r");
    if (fd == 0)
      stop_on_error("cannot open the trace file tb/fe_trace.txt");
    while ($fgets(line, fd) != 0)
    begin
      kind = (line.len() > 0) ? line.getc(0) : "#";
      case (kind)
        "M":
        begin
          void'($sscanf(line, "M %h %h", v0, v1));
          mem[v0] = v1;
        end
        "R":
        begin
          void'($sscanf(line, "R %d %h %h %h %h %h %h", cyc, v0, v1, v2, v3, v4, v5));
          r_cyc.push_back(cyc);
          r_pc.push_back(v0);
          r_bits.push_back({v1[0], v2[0], v3[0]});
          r_br_pc.push_back(v4);
          r_meta.push_back(fe_br_meta_s'(v5[16:0]));
        end
        "A":
        begin
          void'($sscanf(line, "A %d %h %h %h %h", cyc, v0, v1, v2, v3));
          a_cyc.push_back(cyc);
          a_taken.push_back(v0[0]);
          a_pc.push_back(v1);
          a_tgt.push_back(v2);
          a_meta.push_back(fe_br_meta_s'(v3[16:0]));
        end
        "E":
        begin
          void'($sscanf(line, "E %h %h %h", v0, v1, v2));
          e_pc.push_back(v0);
          e_ovr.push_back(v1);
          e_chk.push_back(v2);
        end
        default: ;
      endcase
    end
    $fclose(fd);
  endtask

  // Cycle limit
  initial
  begin
    cycles = 0;
    forever
    begin
      @(posedge clk_i);
      cycles++;
      if (cycles > limit)
        stop_on_error("timeout: the fetch stream did not finish in time");
    end
  end

  initial
  begin
    int cyc;
    int idx;
    int init_wait;
    bit started;
    logic [31:0] pend;
    logic s0_v, s1_v;
    logic [31:0] s0_pc, s1_pc;
    {redirect_v_i, redirect_br_v_i, redirect_br_taken_i, redirect_br_nonbr_i} = '0;
    {redirect_pc_i, redirect_br_pc_i, redirect_meta_i} = '0;
    {attaboy_v_i, attaboy_taken_i, attaboy_pc_i, attaboy_tgt_i, attaboy_meta_i} = '0;
    fetch_i = '0;
    fetch_v_i = 1'b0;
    rst_i = 1'b1;
    limit = 1000;
    load_trace();
    limit = int'(rst_cycles) + (1 << idx_width) + 40 * e_pc.size();
    {s0_v, s1_v, s0_pc, s1_pc} = '0;
    started = 0;
    cyc = 0;
    idx = 0;
    init_wait = 0;
    pend = 0;
    repeat (rst_cycles) @(posedge clk_i);
    #2 rst_i = 1'b0;
    while (!(started && idx == e_pc.size() && pend == 0))
    begin
      ////////////////////
      // Drive, 2 ns after the edge
      if (!started && init_done_o)
      begin
        started = 1;
        // One table entry cleared per cycle after reset
        check_word("cycles to init_done_o", init_wait, 32'(1 << idx_width));
      end
      redirect_v_i = 1'b0;
      redirect_br_v_i = 1'b0;
      attaboy_v_i = 1'b0;
      while (started && r_cyc.size() > 0 && r_cyc[0] == cyc)
      begin
        redirect_v_i = 1'b1;
        redirect_pc_i = r_pc.pop_front();
        {redirect_br_v_i, redirect_br_taken_i, redirect_br_nonbr_i} = r_bits.pop_front();
        redirect_br_pc_i = r_br_pc.pop_front();
        redirect_meta_i = r_meta.pop_front();
        void'(r_cyc.pop_front());
      end
      while (started && a_cyc.size() > 0 && a_cyc[0] == cyc)
      begin
        attaboy_v_i = 1'b1;
        attaboy_taken_i = a_taken.pop_front();
        attaboy_pc_i = a_pc.pop_front();
        attaboy_tgt_i = a_tgt.pop_front();
        attaboy_meta_i = a_meta.pop_front();
        void'(a_cyc.pop_front());
      end
      fetch_v_i = s1_v;
      fetch_i = s1_v ? mem_word(s1_pc) : 32'h0;
      #16;
      ////////////////////
      // Sample, just before the next edge
      if (!started)
      begin
        check_word("fetch_instr_v_o", 32'(fetch_instr_v_o), 32'h0);
        check_word("ovr_o", 32'(ovr_o), 32'h0);
        init_wait++;
      end
      // Metadata lags its instruction by one cycle
      if (pend == 1)
        check_word("fetch_meta_o.is_ret", 32'(fetch_meta_o.is_ret), 32'h1);
      else if (pend == 2)
        check_word("fetch_meta_o.src_btb", 32'(fetch_meta_o.src_btb), 32'h1);
      pend = 0;
      if (fetch_instr_v_o)
      begin
        if (idx >= e_pc.size())
          stop_on_error("fetch reported after the last expected PC");
        check_word("fetch_pc_o", fetch_pc_o, e_pc[idx]);
        check_word("fetch_instr_o", fetch_instr_o, mem_word(e_pc[idx]));
        check_word("ovr_o", 32'(ovr_o), e_ovr[idx]);
        pend = e_chk[idx];
        idx++;
      end
      // Two-deep memory pipe, IF1 entry dies on override or redirect
      s1_v = s0_v && !ovr_o && !redirect_v_i;
      s1_pc = s0_pc;
      s0_v = init_done_o;
      s0_pc = next_fetch_o;
      if (started)
        cyc++;
      @(posedge clk_i);
      #2;
    end
    if (r_cyc.size() == 0 && a_cyc.size() == 0)
    begin
      $display("Result: PASSED");
      $finish;
    end
    else
      stop_on_error("trace events left over at the end of the run");
  end

endmodule

// File: tb/fe_trace.txt
# M addr instr | R cycle pc br_v taken nonbr br_pc meta | A cycle taken pc tgt meta
# E pc ovr chk (chk 0 none, 1 meta is_ret, 2 meta src_btb); cycles count from init_done
M 00000110 0400006f
M 00000150 100000ef
M 00000258 00008067
M 00000160 04000063
M 000001b0 04000863
R 20 000001a0 1 1 0 00000160 10001
R 24 0000015c 0 0 0 00000000 00000
A 34 1 000001b0 00000200 10005
A 36 1 000001b0 00000200 10006
R 38 000001ac 1 0 0 00000000 00004
E 00000100 0 0
E 00000104 0 0
E 00000108 0 0
E 0000010c 0 0
E 00000110 1 0
E 00000150 1 0
E 00000250 0 0
E 00000254 0 0
E 00000258 1 1
E 00000154 0 0
E 00000158 0 0
E 0000015c 0 0
E 00000160 0 0
E 00000164 0 0
E 00000168 0 0
E 000001a0 0 0
E 000001a4 0 0
E 0000015c 0 0
E 00000160 0 2
E 000001a0 0 0
E 000001a4 0 0
E 000001a8 0 0
E 000001ac 0 0
E 000001b0 0 0
E 000001b4 0 0
E 000001b8 0 0
E 000001bc 0 0
E 000001c0 0 0
E 000001c4 0 0
E 000001ac 0 0
E 000001b0 0 2
E 00000200 0 0
E 00000204 0 0
E 00000208 0 0
